/* dv/cnn_ref_model.svh */
`ifndef cnn_ref_model_svh
`define cnn_ref_model_svh

////////////////////////////////////////
// Random source
////////////////////////////////////////

// Galois LFSR, taps 32 30 26 25
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'ha300_0000;
    end else begin
        return s >> 1;
    end
endfunction

// One step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// Expected output for one window, oldest pixel first
function automatic int conv_expected(input int p_old, input int p_mid, input int p_new,
                                     input int w0, input int w1, input int w2,
                                     input int bias, input int shift, input bit relu);
    int sum;
    if (relu && p_old < 0) p_old = 0;
    if (relu && p_mid < 0) p_mid = 0;
    if (relu && p_new < 0) p_new = 0;
    sum = p_old * w0 + p_mid * w1 + p_new * w2 + bias;
    sum = sum >>> shift;
    if (sum > 32767) sum = 32767;
    if (sum < -32768) sum = -32768;
    return sum;
endfunction

task automatic check_val(input string name, input logic signed [31:0] actual,
                         input logic signed [31:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
    end
endtask

`endif

/* dv/cnn_layer_quad_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_layer_quad_tb import cnn_quad_pkg::*; ();

    localparam int timeout_cycles = 400;

    logic                       clk_core;
    logic                       rst;
    logic                       job_start;
    logic                       job_complete_ack;
    logic                       config_valid;
    logic                       config_sel;
    cfg_word_u                  config_data;
    logic                       pixel_valid;
    pixel_t                     pixel_data;
    logic                       job_accept;
    logic                       job_complete;
    logic                       config_accept;
    logic                       pixel_ready;
    logic                       result_valid;
    logic signed [result_w-1:0] result_data;

    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          results_seen;
    int          expect_q [$];
    int          cur_w [3];
    int          cur_bias;
    int          cur_len;
    int          cur_shift;
    bit          cur_relu;

    `include "cnn_ref_model.svh"

    cnn_layer_quad DUT (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_complete_ack (job_complete_ack),
        .config_valid     (config_valid),
        .config_sel       (config_sel),
        .config_data      (config_data),
        .pixel_valid      (pixel_valid),
        .pixel_data       (pixel_data),
        .job_accept       (job_accept),
        .job_complete     (job_complete),
        .config_accept    (config_accept),
        .pixel_ready      (pixel_ready),
        .result_valid     (result_valid),
        .result_data      (result_data)
    );

    always #4 clk_core = ~clk_core;

    // Any result with nothing pending is a leak
    always @(negedge clk_core) begin
        if (!rst && result_valid) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("Unexpected result_valid at %0t with no result pending", $time);
            end else begin
                check_val("result_data", result_data, expect_q.pop_front());
                results_seen++;
            end
        end
    end

    task automatic stop_on_timeout(input string what);
        error_count++;
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic write_config(input logic sel, input cfg_word_u word);
        int waited;
        @(posedge clk_core);
        config_valid <= 1'b1;
        config_sel   <= sel;
        config_data  <= word;
        @(negedge clk_core);
        waited = 0;
        while (!config_accept) begin
            if (waited >= timeout_cycles) stop_on_timeout("config_accept");
            @(negedge clk_core);
            waited++;
        end
        check_val("config_accept latency", waited, 1);
        @(posedge clk_core);
        config_valid <= 1'b0;
        @(negedge clk_core);
        check_val("config_accept", config_accept, 1'b0);
    endtask

    task automatic configure(input int w0, input int w1, input int w2, input int bias,
                             input int len, input bit relu, input int shift);
        cfg_word_u word;
        cur_w = '{w0, w1, w2};
        cur_bias  = bias;
        cur_len   = len;
        cur_relu  = relu;
        cur_shift = shift;
        word = '0;
        for (int i = 0; i < num_taps; i++) begin
            word.weights.tap[i] = weight_t'(cur_w[i]);
        end
        word.weights.bias = weight_t'(bias);
        write_config(cfg_sel_weights, word);
        word = '0;
        word.job.cfg.row_length = row_len_w'(len);
        word.job.cfg.relu_en    = relu;
        word.job.cfg.out_shift  = shift_w'(shift);
        write_config(cfg_sel_job, word);
    endtask

    ////////////////////////////////////////
    // One job from start to acknowledged end
    ////////////////////////////////////////
    task automatic run_job(input bit use_gaps);
        int          row [$];
        logic [31:0] bits;
        int          idx;
        int          waited;
        bit          gap;
        for (int i = 0; i < cur_len; i++) begin
            bits = rand_bits(8);
            row.push_back(int'($signed(bits[7:0])));
        end
        for (int k = 2; k < cur_len; k++) begin
            expect_q.push_back(conv_expected(row[k-2], row[k-1], row[k], cur_w[0], cur_w[1],
                                             cur_w[2], cur_bias, cur_shift, cur_relu));
        end
        results_seen = 0;
        @(posedge clk_core);
        job_start <= 1'b1;
        @(negedge clk_core);
        waited = 0;
        while (!job_accept) begin
            if (waited >= timeout_cycles) stop_on_timeout("job_accept");
            @(negedge clk_core);
            waited++;
        end
        // job_start still high, so a second accept would show here
        @(negedge clk_core);
        check_val("job_accept", job_accept, 1'b0);
        @(posedge clk_core);
        job_start <= 1'b0;
        idx = 0;
        waited = 0;
        while (idx < cur_len) begin
            if (waited >= timeout_cycles) stop_on_timeout("pixel stream");
            @(posedge clk_core);
            gap = use_gaps && (rand_bits(2) == 32'd0);
            pixel_valid <= !gap;
            pixel_data  <= pixel_t'(row[idx]);
            @(negedge clk_core);
            check_val("pixel_ready", pixel_ready, 1'b1);
            if (pixel_valid && pixel_ready) idx++;
            waited++;
        end
        @(posedge clk_core);
        pixel_valid <= 1'b0;
        @(negedge clk_core);
        waited = 0;
        while (!job_complete) begin
            check_val("pixel_ready", pixel_ready, 1'b0);
            if (waited >= timeout_cycles) stop_on_timeout("job_complete");
            @(negedge clk_core);
            waited++;
        end
        check_val("result count", results_seen, cur_len - 2);
        check_val("pending results", expect_q.size(), 0);
        // Completion holds until acked
        repeat (3) begin
            @(negedge clk_core);
            check_val("job_complete", job_complete, 1'b1);
        end
        @(posedge clk_core);
        job_complete_ack <= 1'b1;
        @(posedge clk_core);
        job_complete_ack <= 1'b0;
        @(negedge clk_core);
        check_val("job_complete", job_complete, 1'b0);
    endtask

    initial begin
        clk_core         = 1'b0;
        rst              = 1'b1;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        config_valid     = 1'b0;
        config_sel       = 1'b0;
        config_data      = '0;
        pixel_valid      = 1'b0;
        pixel_data       = '0;
        lfsr_state       = 32'h871d_cd3e;
        error_count      = 0;
        check_count      = 0;
        results_seen     = 0;
        repeat (10) @(posedge clk_core);
        rst <= 1'b0;

        configure(3, -2, 5, 7, 16, 1'b0, 0);
        run_job(1'b0);
        configure(20, -9, 14, -30, 16, 1'b1, 0);
        run_job(1'b0);
        // Sums past 16 bits are shifted down
        configure(-128, -128, -128, 127, 20, 1'b0, 3);
        run_job(1'b0);
        // Back to back jobs with gaps in pixel_valid
        configure(127, -128, 127, -128, 12, 1'b0, 0);
        run_job(1'b1);
        configure(-7, 11, 4, 50, 9, 1'b1, 2);
        run_job(1'b1);

        // Idle tail should stay free of results
        repeat (20) @(negedge clk_core);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
logic/cnn_quad_pkg.sv
logic/cnn_config_regs.sv
logic/cnn_job_ctrl.sv
logic/cnn_pixel_window.sv
logic/cnn_mac_stage.sv
logic/cnn_layer_quad.sv
dv/cnn_layer_quad_tb.sv

/* logic/cnn_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_config_regs import cnn_quad_pkg::*; (
    input  wire logic        clk_core,
    input  wire logic        rst,
    input  wire logic        config_valid,
    input  wire logic        config_sel,
    input  wire cfg_word_u   config_data,
    output logic             config_accept,
    output weight_set_t      weights,
    output job_cfg_t         job_cfg
);

    logic cfg_write;

    assign cfg_write = config_valid && config_accept;

    // Accept one cycle after valid, then drop for a cycle
    always_ff @(posedge clk_core) begin
        if (rst) begin
            config_accept <= 1'b0;
        end else begin
            config_accept <= config_valid && !config_accept;
        end
    end

    ////////////////////////////////////////
    // Weight set and job settings
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            weights <= '0;
            job_cfg <= '0;
        end else if (cfg_write) begin
            case (config_sel)
                cfg_sel_weights: weights <= config_data.weights;
                cfg_sel_job:     job_cfg <= config_data.job.cfg;
                default:         ;
            endcase
        end
    end

    a_sel_known: assert property (@(posedge clk_core) disable iff (rst)
        config_valid |-> !$isunknown(config_sel));

endmodule

`default_nettype wire

/* logic/cnn_job_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_job_ctrl import cnn_quad_pkg::*; (
    input  wire logic          clk_core,
    input  wire logic          rst,
    input  wire logic          job_start,
    input  wire logic          job_complete_ack,
    input  wire logic          pixel_valid,
    input  wire pixel_t        pixel_data,
    input  wire job_cfg_t      job_cfg,
    input  wire result_beat_t  result,
    output logic               job_accept,
    output logic               pixel_ready,
    output logic               job_complete,
    output pix_beat_t          pix_beat
);

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_complete
    } state_t;

    state_t               state;
    logic [row_len_w-1:0] pix_count;
    logic                 pixel_fire;
    logic                 pixel_last;

    ////////////////////////////////////////
    // Handshake outputs
    ////////////////////////////////////////
    assign job_accept   = (state == st_idle) && job_start;
    assign pixel_ready  = (state == st_fetch) && (pix_count != job_cfg.row_length);
    assign job_complete = (state == st_complete);
    assign pixel_fire   = pixel_valid && pixel_ready;
    assign pixel_last   = (pix_count == job_cfg.row_length - row_len_w'(1));

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:     if (job_start) state <= st_fetch;
                // Stay here until the final result drains
                st_fetch:    if (result.valid && result.last) state <= st_complete;
                st_complete: if (job_complete_ack) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    // Accepted pixels in the current row
    always_ff @(posedge clk_core) begin
        if (rst || job_accept) begin
            pix_count <= '0;
        end else if (pixel_fire) begin
            pix_count <= pix_count + row_len_w'(1);
        end
    end

    ////////////////////////////////////////
    // Beat to the window, one cycle later
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        pix_beat.pixel <= pixel_data;
        if (rst) begin
            pix_beat.valid <= 1'b0;
            pix_beat.last  <= 1'b0;
        end else begin
            pix_beat.valid <= pixel_fire;
            pix_beat.last  <= pixel_fire && pixel_last;
        end
    end

    a_row_min: assert property (@(posedge clk_core) disable iff (rst)
        job_accept |-> job_cfg.row_length >= row_len_w'(3));

endmodule

`default_nettype wire

/* logic/cnn_layer_quad.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_layer_quad import cnn_quad_pkg::*; (
    input  wire logic                 clk_core,
    input  wire logic                 rst,
    input  wire logic                 job_start,
    input  wire logic                 job_complete_ack,
    input  wire logic                 config_valid,
    input  wire logic                 config_sel,
    input  wire cfg_word_u            config_data,
    input  wire logic                 pixel_valid,
    input  wire pixel_t               pixel_data,
    output logic                      job_accept,
    output logic                      job_complete,
    output logic                      config_accept,
    output logic                      pixel_ready,
    output logic                      result_valid,
    output logic signed [result_w-1:0] result_data
);

    weight_set_t  weights;
    job_cfg_t     job_cfg;
    pix_beat_t    pix_beat;
    tap_window_t  window;
    result_beat_t result;

    ////////////////////////////////////////
    // Config and job control
    ////////////////////////////////////////
    cnn_config_regs u_config_regs (
        .clk_core      (clk_core),
        .rst           (rst),
        .config_valid  (config_valid),
        .config_sel    (config_sel),
        .config_data   (config_data),
        .config_accept (config_accept),
        .weights       (weights),
        .job_cfg       (job_cfg)
    );

    cnn_job_ctrl u_job_ctrl (
        .clk_core         (clk_core),
        .rst              (rst),
        .job_start        (job_start),
        .job_complete_ack (job_complete_ack),
        .pixel_valid      (pixel_valid),
        .pixel_data       (pixel_data),
        .job_cfg          (job_cfg),
        .result           (result),
        .job_accept       (job_accept),
        .pixel_ready      (pixel_ready),
        .job_complete     (job_complete),
        .pix_beat         (pix_beat)
    );

    ////////////////////////////////////////
    // Compute path
    ////////////////////////////////////////
    cnn_pixel_window u_pixel_window (
        .clk_core   (clk_core),
        .rst        (rst),
        .job_accept (job_accept),
        .relu_en    (job_cfg.relu_en),
        .pix_beat   (pix_beat),
        .window     (window)
    );

    cnn_mac_stage u_mac_stage (
        .clk_core  (clk_core),
        .rst       (rst),
        .window    (window),
        .weights   (weights),
        .out_shift (job_cfg.out_shift),
        .result    (result)
    );

    assign result_valid = result.valid;
    assign result_data  = result.data;

endmodule

`default_nettype wire

/* logic/cnn_mac_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_mac_stage import cnn_quad_pkg::*; (
    input  wire logic               clk_core,
    input  wire logic               rst,
    input  wire tap_window_t        window,
    input  wire weight_set_t        weights,
    input  wire logic [shift_w-1:0] out_shift,
    output result_beat_t            result
);

    logic signed [pixel_w+weight_w-1:0] prod [num_taps];
    logic                               s1_valid;
    logic                               s1_last;
    logic signed [acc_w-1:0]            acc_sum;
    logic signed [acc_w-1:0]            acc_shift;
    logic signed [result_w-1:0]         acc_sat;

    ////////////////////////////////////////
    // Stage one, products
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        for (int i = 0; i < num_taps; i++) begin
            prod[i] <= window.tap[i] * weights.tap[i];
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= window.valid;
            s1_last  <= window.valid && window.last;
        end
    end

    // Sum with bias, arithmetic shift, clamp to 16 bits
    always_comb begin
        acc_sum = acc_w'(weights.bias);
        for (int i = 0; i < num_taps; i++) begin
            acc_sum = acc_sum + prod[i];
        end
        acc_shift = acc_sum >>> out_shift;
        if (acc_shift > result_max) begin
            acc_sat = result_w'(result_max);
        end else if (acc_shift < result_min) begin
            acc_sat = result_w'(result_min);
        end else begin
            acc_sat = acc_shift[result_w-1:0];
        end
    end

    ////////////////////////////////////////
    // Stage two, result register
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        result.data <= acc_sat;
        if (rst) begin
            result.valid <= 1'b0;
            result.last  <= 1'b0;
        end else begin
            result.valid <= s1_valid;
            result.last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

/* logic/cnn_pixel_window.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_pixel_window import cnn_quad_pkg::*; (
    input  wire logic       clk_core,
    input  wire logic       rst,
    input  wire logic       job_accept,
    input  wire logic       relu_en,
    input  wire pix_beat_t  pix_beat,
    output tap_window_t     window
);

    pixel_t     pix_act;
    logic [1:0] fill;
    logic       filled;

    // ReLU zeroes anything with the sign bit set
    assign pix_act = (relu_en && pix_beat.pixel[pixel_w-1]) ? '0 : pix_beat.pixel;

    // Two older pixels already held, so this beat completes a window
    assign filled = (fill >= 2'd2);

    ////////////////////////////////////////
    // Fill count since job_accept
    ////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || job_accept) begin
            fill <= '0;
        end else if (pix_beat.valid && fill != 2'd3) begin
            fill <= fill + 2'd1;
        end
    end

    // Shift register, newest pixel enters at the top tap
    always_ff @(posedge clk_core) begin
        if (pix_beat.valid) begin
            for (int i = 0; i < num_taps - 1; i++) begin
                window.tap[i] <= window.tap[i+1];
            end
            window.tap[num_taps-1] <= pix_act;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            window.valid <= 1'b0;
            window.last  <= 1'b0;
        end else begin
            window.valid <= pix_beat.valid && filled;
            window.last  <= pix_beat.valid && pix_beat.last;
        end
    end

    a_last_filled: assert property (@(posedge clk_core) disable iff (rst)
        (pix_beat.valid && pix_beat.last) |-> filled);

endmodule

`default_nettype wire

/* logic/cnn_quad_pkg.sv */
`default_nettype none

package cnn_quad_pkg;

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////
    localparam int pixel_w   = 8;
    localparam int weight_w  = 8;
    localparam int num_taps  = 3;
    localparam int result_w  = 16;
    localparam int acc_w     = 20;
    localparam int row_len_w = 10;
    localparam int shift_w   = 3;
    localparam int cfg_w     = 32;

    // Saturation limits of the output word
    localparam int result_max = 2 ** (result_w - 1) - 1;
    localparam int result_min = -(2 ** (result_w - 1));

    // Values of config_sel
    localparam logic cfg_sel_weights = 1'b0;
    localparam logic cfg_sel_job     = 1'b1;

    typedef logic signed [pixel_w-1:0]  pixel_t;
    typedef logic signed [weight_w-1:0] weight_t;

    typedef struct packed {
        weight_t [num_taps-1:0] tap;    // tap 0 meets the oldest pixel
        weight_t                bias;
    } weight_set_t;

    typedef struct packed {
        logic [row_len_w-1:0] row_length;
        logic                 relu_en;
        logic [shift_w-1:0]   out_shift;
    } job_cfg_t;

    typedef struct packed {
        logic [cfg_w-row_len_w-shift_w-2:0] reserved;
        job_cfg_t                           cfg;
    } job_word_t;

    ////////////////////////////////////////
    // Config word, two views
    ////////////////////////////////////////
    typedef union packed {
        weight_set_t weights;
        job_word_t   job;
    } cfg_word_u;

    typedef struct packed {
        logic   valid;
        logic   last;
        pixel_t pixel;
    } pix_beat_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        pixel_t [num_taps-1:0] tap;
    } tap_window_t;

    typedef struct packed {
        logic                       valid;
        logic                       last;
        logic signed [result_w-1:0] data;
    } result_beat_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f filelist.f --top-module cnn_layer_quad_tb \
    -o cnn_sim > build.log 2>&1 &&
./obj_dir/cnn_sim > sim.log 2>&1 ;
cat sim.log ;
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
